//--- exe_trace.txt
// en instr pc_plus4 load_data | wen addr wdata | j_valid j_addr b_valid b_addr
// expected columns are the outputs one cycle after the line is driven; ff ends the trace
1 ac1d0000 00000000 00000000  1 00000000 00003fff  0 0000000 0 0000  // sw r29, 0(r0)
1 ac000004 00000000 00000000  1 00000004 00000000  0 0000000 0 0000  // sw r0, 4(r0)
1 2401fffb 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // addiu r1, r0, -5
1 3c021234 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // lui r2, 0x1234
0 00000000 00000000 00000000  0 00000000 00000000  0 0000000 0 0000
1 34428765 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // ori r2, r2, 0x8765
1 ac010010 00000000 00000000  1 00000010 fffffffb  0 0000000 0 0000  // sw r1, 0x10(r0)
1 ac020014 00000000 00000000  1 00000014 12348765  0 0000000 0 0000  // sw r2, 0x14(r0)
1 00221821 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // addu r3, r1, r2
1 00222023 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // subu r4, r1, r2
1 0022282a 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // slt r5, r1, r2
1 0022302b 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // sltu r6, r1, r2
1 00223824 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // and r7, r1, r2
1 00224026 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // xor r8, r1, r2
1 00404827 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // nor r9, r2, r0
1 00015043 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // sra r10, r1, 1
1 00015902 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // srl r11, r1, 4
1 00a26004 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // sllv r12, r2, r5
0 00000000 00000000 00000000  0 00000000 00000000  0 0000000 0 0000
1 ac030020 00000000 00000000  1 00000020 12348760  0 0000000 0 0000
1 ac040024 00000000 00000000  1 00000024 edcb7896  0 0000000 0 0000
1 ac050028 00000000 00000000  1 00000028 00000001  0 0000000 0 0000
1 ac06002c 00000000 00000000  1 0000002c 00000000  0 0000000 0 0000
1 ac070030 00000000 00000000  1 00000030 12348761  0 0000000 0 0000
1 ac080034 00000000 00000000  1 00000034 edcb789e  0 0000000 0 0000
1 ac090038 00000000 00000000  1 00000038 edcb789a  0 0000000 0 0000
1 ac0a003c 00000000 00000000  1 0000003c fffffffd  0 0000000 0 0000
1 ac0b0040 00000000 00000000  1 00000040 0fffffff  0 0000000 0 0000
1 ac0c0044 00000000 00000000  1 00000044 24690eca  0 0000000 0 0000
1 00220018 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // mult r1, r2
1 00006810 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // mfhi r13
1 00007012 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // mflo r14
1 00220019 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // multu r1, r2
1 00007810 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // mfhi r15
1 00008012 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // mflo r16
1 ac0d0050 00000000 00000000  1 00000050 ffffffff  0 0000000 0 0000
1 ac0e0054 00000000 00000000  1 00000054 a4f95b07  0 0000000 0 0000
1 ac0f0058 00000000 00000000  1 00000058 12348764  0 0000000 0 0000
1 ac10005c 00000000 00000000  1 0000005c a4f95b07  0 0000000 0 0000
1 8fb1ffff 00000000 00000000  0 00003ffe 00000000  0 0000000 0 0000  // lw r17, -1(r29)
0 00000000 00000000 cafef00d  0 00000000 00000000  0 0000000 0 0000
1 ac110060 00000000 00000000  1 00000060 cafef00d  0 0000000 0 0000  // sw r17, 0x60(r0)
1 8c320008 00000000 00000000  0 00000003 00000000  0 0000000 0 0000  // lw r18, 8(r1)
0 00000000 00000000 80000001  0 00000000 00000000  0 0000000 0 0000
1 afb2fffc 00000000 00000000  1 00003ffb 80000001  0 0000000 0 0000  // sw r18, -4(r29)
1 10210010 00000000 00000000  0 00000000 00000000  0 0000000 1 0010  // beq r1, r1 taken
1 10220020 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // beq r1, r2
1 1422fff0 00000000 00000000  0 00000000 00000000  0 0000000 1 fff0  // bne r1, r2 taken
1 14630004 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // bne r3, r3
1 08123456 00000000 00000000  0 00000000 00000000  1 0123456 0 0000  // j
1 0fabcdef 00400024 00000000  0 00000000 00000000  1 3abcdef 0 0000  // jal
1 00400008 00000000 00000000  0 00000000 00000000  1 2348765 0 0000  // jr r2
1 ac1f0070 00000000 00000000  1 00000070 00400024  0 0000000 0 0000  // sw r31, 0x70(r0)
0 ac1d0000 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // disabled sw
0 08123456 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // disabled j
0 10000001 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // disabled beq
0 24010007 00000000 00000000  0 00000000 00000000  0 0000000 0 0000  // disabled addiu r1
1 ac010074 00000000 00000000  1 00000074 fffffffb  0 0000000 0 0000  // r1 unchanged
ff

//--- verilog.f
isa_pkg.sv
core_pkg.sv
exe_decoder.sv
reg_file.sv
alu_unit.sv
hilo_unit.sv
branch_unit.sv
mem_unit.sv
exe_top.sv
tb_exe_top.sv

//--- Bender.yml
package:
  name: exe_stage

sources:
  - files:
      - isa_pkg.sv
      - core_pkg.sv
      - exe_decoder.sv
      - reg_file.sv
      - alu_unit.sv
      - hilo_unit.sv
      - branch_unit.sv
      - mem_unit.sv
      - exe_top.sv
  - target: test
    files:
      - tb_exe_top.sv

//--- tb_exe_top.sv
module tb_exe_top;
    import isa_pkg::*;
    import core_pkg::*;

    localparam int          FIELDS      = 11;       // words per trace record
    localparam int          MAX_RECORDS = 128;
    localparam int          RESET_LIMIT = 20;       // cycles
    localparam logic [31:0] END_MARK    = 32'h0000_00ff;

    logic     clk_i;
    logic     reset_i;
    logic     exe_en_i;
    instr_u   instr_i;
    word_t    pc_plus4_i;
    word_t    load_data_i;
    mem_req_t mem_o;
    flow_t    flow_o;

    logic [31:0] trace_words [FIELDS*MAX_RECORDS];
    mem_req_t    exp_mem;
    flow_t       exp_flow;

    exe_top #(
        .SP_RESET (32'h0000_3fff)
    ) uut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .exe_en_i    (exe_en_i),
        .instr_i     (instr_i),
        .pc_plus4_i  (pc_plus4_i),
        .load_data_i (load_data_i),
        .mem_o       (mem_o),
        .flow_o      (flow_o)
    );

    //////////////////////////////////////////////////
    // clock and reset

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    initial begin
        reset_i = 1'b1;
        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;
    end

    //////////////////////////////////////////////////
    // checks

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_mem(input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            $display("Error at time %0t: mem_o does not match the trace", $time);
            $display("    got      wen=%0b addr=%h wdata=%h", got.wen, got.addr, got.wdata);
            $display("    expected wen=%0b addr=%h wdata=%h", exp.wen, exp.addr, exp.wdata);
            abort_run("memory request mismatch");
        end
    endtask

    task automatic check_flow(input flow_t got, input flow_t exp);
        if (got !== exp) begin
            $display("Error at time %0t: flow_o does not match the trace", $time);
            $display("    got      j_valid=%0b j_addr=%h b_valid=%0b b_addr=%h",
                     got.j_valid, got.j_addr, got.b_valid, got.b_addr);
            $display("    expected j_valid=%0b j_addr=%h b_valid=%0b b_addr=%h",
                     exp.j_valid, exp.j_addr, exp.b_valid, exp.b_addr);
            abort_run("control flow mismatch");
        end
    endtask

    //////////////////////////////////////////////////
    // trace access

    function automatic mem_req_t mem_from_trace(input int base);
        mem_req_t m;
        m.wen   = trace_words[base+4][0];
        m.addr  = trace_words[base+5];
        m.wdata = trace_words[base+6];
        return m;
    endfunction

    function automatic flow_t flow_from_trace(input int base);
        flow_t f;
        f.j_valid = trace_words[base+7][0];
        f.j_addr  = trace_words[base+8][25:0];
        f.b_valid = trace_words[base+9][0];
        f.b_addr  = trace_words[base+10][15:0];
        return f;
    endfunction

    task automatic drive_record(input int base);
        exe_en_i    <= trace_words[base][0];
        instr_i     <= trace_words[base+1];
        pc_plus4_i  <= trace_words[base+2];
        load_data_i <= trace_words[base+3];
    endtask

    task automatic drive_idle();
        exe_en_i    <= 1'b0;
        instr_i     <= '0;
        pc_plus4_i  <= '0;
        load_data_i <= '0;
    endtask

    //////////////////////////////////////////////////
    // trace replay

    initial begin
        int   wait_cycles;
        int   rec;
        int   base;
        logic done;

        exe_en_i    = 1'b0;
        instr_i     = '0;
        pc_plus4_i  = '0;
        load_data_i = '0;
        exp_mem     = '0;
        exp_flow    = '0;
        wait_cycles = 0;
        rec         = 0;
        base        = 0;
        done        = 1'b0;
        $readmemh("exe_trace.txt", trace_words);

        while (reset_i !== 1'b0) begin
            if (wait_cycles >= RESET_LIMIT) begin
                abort_run("reset was not released in time");
            end else begin
                @(posedge clk_i);
                wait_cycles++;
            end
        end

        // expected values of a record show up one cycle after it is driven
        while (!done) begin
            base = rec * FIELDS;
            if (rec >= MAX_RECORDS) begin
                abort_run("trace has no end marker within the record limit");
            end else if ($isunknown(trace_words[base])) begin
                abort_run("trace ended without an end marker");
            end else begin
                @(posedge clk_i);
                if (trace_words[base] == END_MARK) begin
                    drive_idle();
                    done = 1'b1;
                end else begin
                    drive_record(base);
                end
                @(negedge clk_i);                       // outputs stable mid-cycle
                check_mem(mem_o, exp_mem);
                check_flow(flow_o, exp_flow);
                exp_mem  = mem_from_trace(base);
                exp_flow = flow_from_trace(base);
                rec++;
            end
        end

        if (rec <= 1) begin
            abort_run("trace held no records");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

//--- exe_top.sv
module exe_top #(
    parameter core_pkg::word_t SP_RESET = 32'h0000_3fff
) (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               exe_en_i,
    input  isa_pkg::instr_u    instr_i,
    input  core_pkg::word_t    pc_plus4_i,
    input  core_pkg::word_t    load_data_i,
    output core_pkg::mem_req_t mem_o,
    output core_pkg::flow_t    flow_o
);
    import isa_pkg::*;
    import core_pkg::*;

    dec_t  dec;
    word_t rs_data;
    word_t rt_data;
    word_t hi;
    word_t lo;
    wb_t   alu_wb;
    wb_t   load_wb;

    //////////////////////////////////////////////////
    // decode and operand read

    exe_decoder u_decoder (
        .instr_i  (instr_i),
        .exe_en_i (exe_en_i),
        .dec_o    (dec)
    );

    reg_file #(
        .SP_RESET (SP_RESET)
    ) u_reg_file (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .rs_idx_i  (dec.rs),
        .rt_idx_i  (dec.rt),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data),
        .alu_wb_i  (alu_wb),
        .load_wb_i (load_wb)
    );

    //////////////////////////////////////////////////
    // execution units

    alu_unit u_alu (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .dec_i      (dec),
        .rs_data_i  (rs_data),
        .rt_data_i  (rt_data),
        .hi_i       (hi),
        .lo_i       (lo),
        .pc_plus4_i (pc_plus4_i),
        .wb_o       (alu_wb)
    );

    hilo_unit u_hilo (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .dec_i     (dec),
        .rs_data_i (rs_data),
        .rt_data_i (rt_data),
        .hi_o      (hi),
        .lo_o      (lo)
    );

    branch_unit u_branch (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .dec_i     (dec),
        .rs_data_i (rs_data),
        .rt_data_i (rt_data),
        .flow_o    (flow_o)
    );

    mem_unit u_mem (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .dec_i       (dec),
        .rs_data_i   (rs_data),
        .rt_data_i   (rt_data),
        .load_data_i (load_data_i),
        .mem_o       (mem_o),
        .load_wb_o   (load_wb)
    );

endmodule

//--- mem_unit.sv
module mem_unit (
    input  logic               clk_i,
    input  logic               reset_i,
    input  isa_pkg::dec_t      dec_i,
    input  core_pkg::word_t    rs_data_i,
    input  core_pkg::word_t    rt_data_i,
    input  core_pkg::word_t    load_data_i,
    output core_pkg::mem_req_t mem_o,
    output core_pkg::wb_t      load_wb_o
);
    import isa_pkg::*;
    import core_pkg::*;

    mem_req_t req;
    logic     ld_pend_q;
    reg_idx_t ld_idx_q;

    always_comb begin
        req = '0;
        if (dec_i.op == OP_LW || dec_i.op == OP_SW) begin
            req.addr = rs_data_i + dec_i.imm;   // base plus offset
        end
        if (dec_i.op == OP_SW) begin
            req.wen   = 1'b1;
            req.wdata = rt_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mem_o     <= '0;
            ld_pend_q <= 1'b0;
        end else begin
            mem_o     <= req;
            ld_pend_q <= (dec_i.op == OP_LW);
        end
    end

    always_ff @(posedge clk_i) begin
        ld_idx_q <= dec_i.dst;
    end

    // load data arrives one cycle after the address
    assign load_wb_o = '{valid: ld_pend_q, idx: ld_idx_q, data: load_data_i};

endmodule

//--- branch_unit.sv
module branch_unit (
    input  logic            clk_i,
    input  logic            reset_i,
    input  isa_pkg::dec_t   dec_i,
    input  core_pkg::word_t rs_data_i,
    input  core_pkg::word_t rt_data_i,
    output core_pkg::flow_t flow_o
);
    import isa_pkg::*;
    import core_pkg::*;

    flow_t flow_d;
    logic  rs_eq_rt;

    assign rs_eq_rt = (rs_data_i == rt_data_i);

    always_comb begin
        flow_d = '0;
        case (dec_i.op)
            OP_J, OP_JAL: begin
                flow_d.j_valid = 1'b1;
                flow_d.j_addr  = dec_i.target;
            end
            OP_JR: begin
                flow_d.j_valid = 1'b1;
                flow_d.j_addr  = rs_data_i[25:0];
            end
            OP_BEQ, OP_BNE: begin
                if ((dec_i.op == OP_BEQ) == rs_eq_rt) begin   // taken
                    flow_d.b_valid = 1'b1;
                    flow_d.b_addr  = dec_i.imm[15:0];
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            flow_o <= '0;
        end else begin
            flow_o <= flow_d;
        end
    end

endmodule

//--- hilo_unit.sv
module hilo_unit (
    input  logic            clk_i,
    input  logic            reset_i,
    input  isa_pkg::dec_t   dec_i,
    input  core_pkg::word_t rs_data_i,
    input  core_pkg::word_t rt_data_i,
    output core_pkg::word_t hi_o,
    output core_pkg::word_t lo_o
);
    import isa_pkg::*;
    import core_pkg::*;

    logic [2*XLEN-1:0] prod;

    always_comb begin
        if (dec_i.op == OP_MULT) begin
            prod = $signed(rs_data_i) * $signed(rt_data_i);   // sign-extended to 64
        end else begin
            prod = rs_data_i * rt_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            hi_o <= '0;
            lo_o <= '0;
        end else if (dec_i.op == OP_MULT || dec_i.op == OP_MULTU) begin
            {hi_o, lo_o} <= prod;
        end
    end

endmodule

//--- alu_unit.sv
module alu_unit (
    input  logic            clk_i,
    input  logic            reset_i,
    input  isa_pkg::dec_t   dec_i,
    input  core_pkg::word_t rs_data_i,
    input  core_pkg::word_t rt_data_i,
    input  core_pkg::word_t hi_i,
    input  core_pkg::word_t lo_i,
    input  core_pkg::word_t pc_plus4_i,
    output core_pkg::wb_t   wb_o
);
    import isa_pkg::*;
    import core_pkg::*;

    word_t result;
    logic  writes;

    //////////////////////////////////////////////////
    // result select

    always_comb begin
        result = '0;
        writes = 1'b1;
        case (dec_i.op)
            OP_SLL:   result = rt_data_i << dec_i.shamt;
            OP_SRL:   result = rt_data_i >> dec_i.shamt;
            OP_SRA:   result = $signed(rt_data_i) >>> dec_i.shamt;
            OP_SLLV:  result = rt_data_i << rs_data_i[4:0];
            OP_SRLV:  result = rt_data_i >> rs_data_i[4:0];
            OP_SRAV:  result = $signed(rt_data_i) >>> rs_data_i[4:0];
            OP_ADD,
            OP_ADDU:  result = rs_data_i + rt_data_i;         // no overflow trap
            OP_SUB,
            OP_SUBU:  result = rs_data_i - rt_data_i;
            OP_AND:   result = rs_data_i & rt_data_i;
            OP_OR:    result = rs_data_i | rt_data_i;
            OP_XOR:   result = rs_data_i ^ rt_data_i;
            OP_NOR:   result = ~(rs_data_i | rt_data_i);
            OP_SLT:   result = word_t'($signed(rs_data_i) < $signed(rt_data_i));
            OP_SLTU:  result = word_t'(rs_data_i < rt_data_i);
            OP_ADDI,
            OP_ADDIU: result = rs_data_i + dec_i.imm;
            OP_SLTI:  result = word_t'($signed(rs_data_i) < $signed(dec_i.imm));
            OP_SLTIU: result = word_t'(rs_data_i < dec_i.imm);  // sign-extended, unsigned compare
            OP_ANDI:  result = rs_data_i & dec_i.imm;
            OP_ORI:   result = rs_data_i | dec_i.imm;
            OP_XORI:  result = rs_data_i ^ dec_i.imm;
            OP_LUI:   result = {dec_i.imm[15:0], 16'h0000};
            OP_MFHI:  result = hi_i;
            OP_MFLO:  result = lo_i;
            OP_JAL:   result = pc_plus4_i;                    // link value
            default:  writes = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // writeback register

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_o <= '0;
        end else begin
            wb_o <= '{valid: writes, idx: dec_i.dst, data: result};
        end
    end

endmodule

//--- reg_file.sv
module reg_file #(
    parameter core_pkg::word_t SP_RESET = 32'h0000_3fff
) (
    input  logic               clk_i,
    input  logic               reset_i,
    input  core_pkg::reg_idx_t rs_idx_i,
    input  core_pkg::reg_idx_t rt_idx_i,
    output core_pkg::word_t    rs_data_o,
    output core_pkg::word_t    rt_data_o,
    input  core_pkg::wb_t      alu_wb_i,
    input  core_pkg::wb_t      load_wb_i
);
    import core_pkg::*;

    word_t regs [32];
    wb_t   wr;

    // load result wins a same-cycle collision
    assign wr = load_wb_i.valid ? load_wb_i : alu_wb_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= (i == 29) ? SP_RESET : '0;   // r29 is the stack pointer
            end
        end else if (wr.valid && wr.idx != '0) begin
            regs[wr.idx] <= wr.data;
        end
    end

    assign rs_data_o = regs[rs_idx_i];
    assign rt_data_o = regs[rt_idx_i];

endmodule

//--- exe_decoder.sv
module exe_decoder (
    input  isa_pkg::instr_u instr_i,
    input  logic            exe_en_i,
    output isa_pkg::dec_t   dec_o
);
    import isa_pkg::*;

    function automatic exe_op_e funct_op(input funct_t fn);
        case (fn)
            FN_SLL:   return OP_SLL;
            FN_SRL:   return OP_SRL;
            FN_SRA:   return OP_SRA;
            FN_SLLV:  return OP_SLLV;
            FN_SRLV:  return OP_SRLV;
            FN_SRAV:  return OP_SRAV;
            FN_JR:    return OP_JR;
            FN_MFHI:  return OP_MFHI;
            FN_MFLO:  return OP_MFLO;
            FN_MULT:  return OP_MULT;
            FN_MULTU: return OP_MULTU;
            FN_ADD:   return OP_ADD;
            FN_ADDU:  return OP_ADDU;
            FN_SUB:   return OP_SUB;
            FN_SUBU:  return OP_SUBU;
            FN_AND:   return OP_AND;
            FN_OR:    return OP_OR;
            FN_XOR:   return OP_XOR;
            FN_NOR:   return OP_NOR;
            FN_SLT:   return OP_SLT;
            FN_SLTU:  return OP_SLTU;
            default:  return OP_NOP;
        endcase
    endfunction

    always_comb begin
        dec_o    = '0;
        dec_o.op = OP_NOP;
        if (exe_en_i) begin
            case (instr_i.r.opcode)
                OPC_SPECIAL: begin
                    dec_o.rs    = instr_i.r.rs;
                    dec_o.rt    = instr_i.r.rt;
                    dec_o.dst   = instr_i.r.rd;
                    dec_o.shamt = instr_i.r.shamt;
                    dec_o.op    = funct_op(instr_i.r.funct);
                end
                OPC_J, OPC_JAL: begin
                    dec_o.target = instr_i.j.target;
                    if (instr_i.j.opcode == OPC_JAL) begin
                        dec_o.op  = OP_JAL;
                        dec_o.dst = 5'd31;          // link register
                    end else begin
                        dec_o.op = OP_J;
                    end
                end
                default: begin
                    dec_o.rs  = instr_i.i.rs;
                    dec_o.rt  = instr_i.i.rt;
                    dec_o.dst = instr_i.i.rt;
                    dec_o.imm = {{16{instr_i.i.imm[15]}}, instr_i.i.imm};
                    case (instr_i.i.opcode)
                        OPC_BEQ:   dec_o.op = OP_BEQ;
                        OPC_BNE:   dec_o.op = OP_BNE;
                        OPC_ADDI:  dec_o.op = OP_ADDI;
                        OPC_ADDIU: dec_o.op = OP_ADDIU;
                        OPC_SLTI:  dec_o.op = OP_SLTI;
                        OPC_SLTIU: dec_o.op = OP_SLTIU;
                        OPC_LW:    dec_o.op = OP_LW;
                        OPC_SW:    dec_o.op = OP_SW;
                        OPC_ANDI:  dec_o.op = OP_ANDI;
                        OPC_ORI:   dec_o.op = OP_ORI;
                        OPC_XORI:  dec_o.op = OP_XORI;
                        OPC_LUI:   dec_o.op = OP_LUI;
                        default:   dec_o.op = OP_NOP;
                    endcase
                    // logical immediates take zeros above
                    if (dec_o.op inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI}) begin
                        dec_o.imm = {16'h0000, instr_i.i.imm};
                    end
                end
            endcase
        end
    end

endmodule

//--- core_pkg.sv
package core_pkg;

    localparam int XLEN = 32;

    typedef logic [4:0]      reg_idx_t;
    typedef logic [XLEN-1:0] word_t;

    // register write request
    typedef struct packed {
        logic     valid;
        reg_idx_t idx;
        word_t    data;
    } wb_t;

    // 32-bit load/store port
    typedef struct packed {
        logic  wen;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic        j_valid;
        logic [25:0] j_addr;   // word target
        logic        b_valid;
        logic [15:0] b_addr;   // raw branch offset
    } flow_t;

endpackage

//--- isa_pkg.sv
package isa_pkg;

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // major opcodes
    localparam opcode_t OPC_SPECIAL = 6'h00;
    localparam opcode_t OPC_J       = 6'h02;
    localparam opcode_t OPC_JAL     = 6'h03;
    localparam opcode_t OPC_BEQ     = 6'h04;
    localparam opcode_t OPC_BNE     = 6'h05;
    localparam opcode_t OPC_ADDI    = 6'h08;
    localparam opcode_t OPC_ADDIU   = 6'h09;
    localparam opcode_t OPC_SLTI    = 6'h0a;
    localparam opcode_t OPC_SLTIU   = 6'h0b;
    localparam opcode_t OPC_ANDI    = 6'h0c;
    localparam opcode_t OPC_ORI     = 6'h0d;
    localparam opcode_t OPC_XORI    = 6'h0e;
    localparam opcode_t OPC_LUI     = 6'h0f;
    localparam opcode_t OPC_LW      = 6'h23;
    localparam opcode_t OPC_SW      = 6'h2b;

    // function codes under OPC_SPECIAL
    localparam funct_t FN_SLL   = 6'h00;
    localparam funct_t FN_SRL   = 6'h02;
    localparam funct_t FN_SRA   = 6'h03;
    localparam funct_t FN_SLLV  = 6'h04;
    localparam funct_t FN_SRLV  = 6'h06;
    localparam funct_t FN_SRAV  = 6'h07;
    localparam funct_t FN_JR    = 6'h08;
    localparam funct_t FN_MFHI  = 6'h10;
    localparam funct_t FN_MFLO  = 6'h12;
    localparam funct_t FN_MULT  = 6'h18;
    localparam funct_t FN_MULTU = 6'h19;
    localparam funct_t FN_ADD   = 6'h20;
    localparam funct_t FN_ADDU  = 6'h21;
    localparam funct_t FN_SUB   = 6'h22;
    localparam funct_t FN_SUBU  = 6'h23;
    localparam funct_t FN_AND   = 6'h24;
    localparam funct_t FN_OR    = 6'h25;
    localparam funct_t FN_XOR   = 6'h26;
    localparam funct_t FN_NOR   = 6'h27;
    localparam funct_t FN_SLT   = 6'h2a;
    localparam funct_t FN_SLTU  = 6'h2b;

    typedef struct packed {
        opcode_t    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_t     funct;
    } instr_r_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } instr_i_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] target;
    } instr_j_t;

    // one word, three views
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_j_t j;
    } instr_u;

    typedef enum logic [5:0] {
        OP_NOP,
        OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
        OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLT, OP_SLTU,
        OP_MULT, OP_MULTU, OP_MFHI, OP_MFLO,
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
        OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
        OP_LW, OP_SW,
        OP_BEQ, OP_BNE, OP_J, OP_JAL, OP_JR
    } exe_op_e;

    typedef struct packed {
        exe_op_e     op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dst;     // register written, if any
        logic [4:0]  shamt;
        logic [31:0] imm;     // already extended
        logic [25:0] target;
    } dec_t;

endpackage
